// File: hw/trs_io_pkg.sv
package trs_io_pkg;

  // command codes sent by the esp over spi
  typedef enum logic [7:0] {
    get_cookie  = 8'd0,
    dbus_write  = 8'd4,   // one param byte
    data_ready  = 8'd5,
    get_version = 8'd15,
    abus_read   = 8'd18,
    set_led     = 8'd26   // one param byte, rgb in bits 0..2
  } cmd_e;

  // service codes shown to the esp on esp_s
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3,
    printer_rd = 4'd4,
    printer_wr = 4'd5,
    idle_code  = 4'd15    // nothing pending
  } esp_code_e;

  // reply bytes
  localparam logic [7:0] COOKIE  = 8'haf;
  localparam logic [7:0] VERSION = {3'd0, 5'd3};   // major 0 minor 3

  // trapped z80 i/o ports
  localparam logic [7:0] TRS_IO_PORT     = 8'd31;
  localparam logic [3:0] FREHD_PORT_HI   = 4'hc;       // c0h..cfh
  localparam logic [5:0] PRINTER_PORT_HI = 6'b111110;  // f8h..fbh

  // parameter bytes of one command, index 0 first on the wire
  typedef logic [1:0][7:0] params_t;

  // flops per input synchronizer
  localparam int SYNC_STAGES = 3;

endpackage

// File: hw/trs_io_ifs.sv
`timescale 1ns/1ps

// byte level link between the spi slave and the command logic
interface spi_link_if;
  logic [7:0] rx_byte;
  logic       rx_valid;   // one cycle per received byte
  logic       msg_start;  // cs fell
  logic       tx_busy;    // reply still shifting out
  logic [7:0] tx_byte;
  logic       tx_load;    // one cycle pulse

  modport port   (output rx_byte, rx_valid, msg_start, tx_busy, input tx_byte, tx_load);
  modport parser (input rx_byte, rx_valid, msg_start);
  modport regs   (output tx_byte, tx_load);
endinterface

// decoded command handed from the parser to the register bank
interface cmd_if import trs_io_pkg::*; ();
  cmd_e    cmd;
  params_t params;
  logic    trigger;   // cmd and params valid in this cycle

  modport parser (output cmd, params, trigger);
  modport regs   (input cmd, params, trigger);
endinterface

// File: hw/spi_byte_port.sv
`timescale 1ns/1ps

module spi_byte_port import trs_io_pkg::*; (
  input  logic     clk,
  input  logic     cass_out_sel_n,
  input  logic     sck,
  input  logic     cs_fpga,
  input  logic     mosi,
  output logic     miso,
  spi_link_if.port link
);

  logic [SYNC_STAGES-1:0] sck_q;   // bit 0 samples the pin
  logic [SYNC_STAGES-1:0] cs_q;
  logic [SYNC_STAGES-1:0] mosi_q;
  logic                   sck_rise;
  logic                   sck_fall;
  logic                   cs_active;
  logic                   cs_fall;
  logic                   mosi_bit;
  logic [2:0]             bit_cnt;   // bits of the current byte
  logic [6:0]             rx_shift;
  logic [7:0]             tx_shift;  // msb drives miso
  logic [3:0]             tx_bits;   // reply bits the master has yet to sample

  // pin synchronizers
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_q  <= '0;
      cs_q   <= '1;   // cs idles high
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[SYNC_STAGES-2:0], sck};
      cs_q   <= {cs_q[SYNC_STAGES-2:0], cs_fpga};
      mosi_q <= {mosi_q[SYNC_STAGES-2:0], mosi};
    end
  end

  assign sck_rise  = sck_q[SYNC_STAGES-2] & ~sck_q[SYNC_STAGES-1];
  assign sck_fall  = ~sck_q[SYNC_STAGES-2] & sck_q[SYNC_STAGES-1];
  assign cs_active = ~cs_q[SYNC_STAGES-2];
  assign cs_fall   = ~cs_q[SYNC_STAGES-2] & cs_q[SYNC_STAGES-1];
  assign mosi_bit  = mosi_q[SYNC_STAGES-1];   // one clock older than the sck edge

  // bit counter and byte strobe
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt        <= '0;
      link.rx_valid  <= 1'b0;
      link.msg_start <= 1'b0;
    end else begin
      link.msg_start <= cs_fall;
      link.rx_valid  <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;   // realign on every frame
      end else if (sck_rise) begin
        bit_cnt       <= bit_cnt + 3'd1;
        link.rx_valid <= (bit_cnt == 3'd7) && !link.tx_busy;   // dummy byte of a reply dropped
      end
    end
  end

  // mosi shifter, msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[5:0], mosi_bit};
      if (bit_cnt == 3'd7)
        link.rx_byte <= {rx_shift, mosi_bit};
    end
  end

  // reply shifter
  // the master samples on rise so a fall only shifts once a bit was taken
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      tx_shift <= '0;
      tx_bits  <= '0;
    end else if (link.tx_load) begin
      tx_shift <= link.tx_byte;   // msb on miso right away
      tx_bits  <= 4'd8;
    end else if (cs_active) begin
      if (sck_rise && link.tx_busy)
        tx_bits <= tx_bits - 4'd1;
      if (sck_fall && tx_bits != 4'd8)
        tx_shift <= {tx_shift[6:0], 1'b0};   // zero fill leaves miso low after
    end
  end

  assign link.tx_busy = (tx_bits != 4'd0);
  assign miso         = tx_shift[7];

endmodule

// File: hw/cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser import trs_io_pkg::*; (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  spi_link_if.parser link,
  cmd_if.parser      cmd
);

  typedef enum logic {
    idle,          // waiting for a command byte
    read_params    // collecting parameter bytes
  } state_e;

  state_e     state;
  logic [1:0] params_left;   // bytes still expected
  logic       param_idx;     // slot for the next byte
  logic       take_param;

  // param bytes only land while the fsm waits for them
  assign take_param = link.rx_valid && (state == read_params);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state       <= idle;
      params_left <= '0;
      param_idx   <= 1'b0;
      cmd.cmd     <= get_cookie;
      cmd.trigger <= 1'b0;
    end else begin
      cmd.trigger <= 1'b0;   // single cycle pulse
      if (link.msg_start) begin
        state <= idle;   // half received command is dropped
      end else if (link.rx_valid) begin
        case (state)
          idle: begin
            cmd.cmd   <= cmd_e'(link.rx_byte);
            param_idx <= 1'b0;
            case (link.rx_byte)
              dbus_write,
              set_led: begin
                params_left <= 2'd1;
                state       <= read_params;
              end
              default: begin
                cmd.trigger <= 1'b1;   // no params or unknown code
              end
            endcase
          end
          read_params: begin
            param_idx   <= param_idx + 1'b1;
            params_left <= params_left - 2'd1;
            if (params_left == 2'd1) begin
              cmd.trigger <= 1'b1;   // last param in
              state       <= idle;
            end
          end
        endcase
      end
    end
  end

  // parameter bytes
  always_ff @(posedge clk) begin
    if (take_param)
      cmd.params[param_idx] <= link.rx_byte;
  end

endmodule

// File: hw/host_regs.sv
`timescale 1ns/1ps

module host_regs import trs_io_pkg::*; (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic [7:0] trs_a,
  input  logic       port31_hit,
  cmd_if.regs        cmd,
  spi_link_if.regs   link,
  output logic [7:0] trs_d_out,
  output logic       trs_int,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic       led_err
);

  logic has_reply;   // command answers with one byte

  always_comb begin
    case (cmd.cmd)
      get_cookie,
      get_version,
      abus_read: has_reply = 1'b1;
      default:   has_reply = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      link.tx_load <= 1'b0;
      trs_d_out    <= '0;
      trs_int      <= 1'b0;
      led_red      <= 1'b0;
      led_green    <= 1'b0;
      led_blue     <= 1'b0;
      led_err      <= 1'b0;
    end else begin
      link.tx_load <= cmd.trigger && has_reply;
      if (port31_hit)
        trs_int <= 1'b0;   // z80 looked at trs-io
      if (cmd.trigger) begin
        case (cmd.cmd)
          dbus_write: trs_d_out <= cmd.params[0];
          data_ready: trs_int <= 1'b1;   // wins over a clear in the same cycle
          set_led: begin
            led_red   <= cmd.params[0][0];
            led_green <= cmd.params[0][1];
            led_blue  <= cmd.params[0][2];
          end
          get_cookie, get_version, abus_read: ;   // reply only
          default: led_err <= 1'b1;   // sticky until reset
        endcase
      end
    end
  end

  // reply byte picked up by the spi port with tx_load
  always_ff @(posedge clk) begin
    if (cmd.trigger) begin
      case (cmd.cmd)
        get_cookie:  link.tx_byte <= COOKIE;
        get_version: link.tx_byte <= VERSION;
        abus_read:   link.tx_byte <= trs_a;   // live bus value
        default: ;
      endcase
    end
  end

endmodule

// File: hw/trs_port_decode.sv
`timescale 1ns/1ps

module trs_port_decode import trs_io_pkg::*; (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       trs_in_n,
  input  logic       trs_out_n,
  input  logic [7:0] trs_a,
  output logic       access_start,
  output logic       sel,
  output logic       port31_hit,
  output logic [3:0] esp_s
);

  logic [SYNC_STAGES-1:0]      in_q;
  logic [SYNC_STAGES-1:0]      out_q;
  logic [SYNC_STAGES-1:0][7:0] a_q;   // address follows the strobes stage for stage
  logic [7:0]                  a_s;
  logic                        rd_s;  // in strobe active
  logic                        wr_s;  // out strobe active
  logic                        access;
  logic                        access_d;
  logic                        io_hit;
  logic                        frehd_hit;
  logic                        prn_hit;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      in_q     <= '1;   // strobes idle high
      out_q    <= '1;
      access_d <= 1'b0;
    end else begin
      in_q     <= {in_q[SYNC_STAGES-2:0], trs_in_n};
      out_q    <= {out_q[SYNC_STAGES-2:0], trs_out_n};
      access_d <= access;
    end
  end

  always_ff @(posedge clk) begin
    a_q <= {a_q[SYNC_STAGES-2:0], trs_a};
  end

  assign a_s          = a_q[SYNC_STAGES-1];
  assign rd_s         = ~in_q[SYNC_STAGES-1];
  assign wr_s         = ~out_q[SYNC_STAGES-1];
  assign access       = rd_s | wr_s;
  assign access_start = access & ~access_d;   // first low cycle

  assign io_hit     = (a_s == TRS_IO_PORT);
  assign frehd_hit  = (a_s[7:4] == FREHD_PORT_HI);
  assign prn_hit    = (a_s[7:2] == PRINTER_PORT_HI);
  assign sel        = io_hit | frehd_hit | prn_hit;
  assign port31_hit = access_start & io_hit;

  // service code only while the strobe stays low
  always_comb begin
    esp_s = idle_code;
    if (access) begin
      if (io_hit)
        esp_s = rd_s ? trs_io_in : trs_io_out;
      else if (frehd_hit)
        esp_s = rd_s ? frehd_in : frehd_out;
      else if (prn_hit)
        esp_s = rd_s ? printer_rd : printer_wr;
    end
  end

endmodule

// File: hw/esp_req_timer.sv
`timescale 1ns/1ps

module esp_req_timer import trs_io_pkg::*; #(
  parameter int REQ_PULSE_CYCLES = 50
) (
  input  logic clk,
  input  logic cass_out_sel_n,
  input  logic access_start,
  input  logic sel,
  input  logic done,
  output logic req,
  output logic trs_wait
);

  localparam int CNT_W = $clog2(REQ_PULSE_CYCLES + 1);

  logic [CNT_W-1:0]       count;    // req cycles left
  logic [SYNC_STAGES-1:0] done_q;
  logic                   done_rise;

  assign done_rise = done_q[SYNC_STAGES-2] & ~done_q[SYNC_STAGES-1];

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      count    <= '0;
      done_q   <= '0;
      trs_wait <= 1'b0;
    end else begin
      done_q <= {done_q[SYNC_STAGES-2:0], done};
      if (access_start && sel) begin
        count    <= CNT_W'(REQ_PULSE_CYCLES);   // also restarts a running pulse
        trs_wait <= 1'b1;   // z80 held until the esp is done
      end else begin
        if (count != '0)
          count <= count - 1'b1;
        if (done_rise)
          trs_wait <= 1'b0;
      end
    end
  end

  assign req = (count != '0);   // exactly REQ_PULSE_CYCLES wide

endmodule

// File: hw/trs_io_top.sv
`timescale 1ns/1ps

module trs_io_top #(
  parameter int REQ_PULSE_CYCLES = 50   // esp req width in clk cycles
) (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       sck,
  input  logic       cs_fpga,
  input  logic       mosi,
  input  logic       trs_in_n,
  input  logic       trs_out_n,
  input  logic       done,
  input  logic [7:0] trs_a,
  output logic       miso,
  output logic [3:0] esp_s,
  output logic       req,
  output logic       trs_wait,
  output logic       trs_int,
  output logic [7:0] trs_d_out,
  output logic       led_red,
  output logic       led_green,
  output logic       led_blue,
  output logic       led_err
);

  spi_link_if link ();
  cmd_if      cmd_bus ();

  logic access_start;
  logic sel;
  logic port31_hit;

  // esp command side
  spi_byte_port spi_byte_port_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_fpga        (cs_fpga),
    .mosi           (mosi),
    .miso           (miso),
    .link           (link.port)
  );

  cmd_parser cmd_parser_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .link           (link.parser),
    .cmd            (cmd_bus.parser)
  );

  host_regs host_regs_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .trs_a          (trs_a),
    .port31_hit     (port31_hit),
    .cmd            (cmd_bus.regs),
    .link           (link.regs),
    .trs_d_out      (trs_d_out),
    .trs_int        (trs_int),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .led_err        (led_err)
  );

  // z80 i/o trap side
  trs_port_decode trs_port_decode_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .trs_in_n       (trs_in_n),
    .trs_out_n      (trs_out_n),
    .trs_a          (trs_a),
    .access_start   (access_start),
    .sel            (sel),
    .port31_hit     (port31_hit),
    .esp_s          (esp_s)
  );

  esp_req_timer #(
    .REQ_PULSE_CYCLES (REQ_PULSE_CYCLES)
  ) esp_req_timer_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .access_start   (access_start),
    .sel            (sel),
    .done           (done),
    .req            (req),
    .trs_wait       (trs_wait)
  );

endmodule

// File: tests/trs_io_tb.sv
`timescale 1ns/1ps

module trs_io_tb import trs_io_pkg::*;;

  localparam int REQ_CYCLES = 50;   // req width handed to the dut
  localparam int WAIT_LIMIT = 20;   // cycles before a wait loop gives up

  logic       clk;
  logic       cass_out_sel_n;
  logic       sck;
  logic       cs_fpga;
  logic       mosi;
  logic       trs_in_n;
  logic       trs_out_n;
  logic       done;
  logic [7:0] trs_a;
  logic       miso;
  logic [3:0] esp_s;
  logic       req;
  logic       trs_wait;
  logic       trs_int;
  logic [7:0] trs_d_out;
  logic       led_red;
  logic       led_green;
  logic       led_blue;
  logic       led_err;

  // model state
  logic       exp_red;
  logic       exp_green;
  logic       exp_blue;
  logic       exp_err;
  logic       exp_int;
  logic [7:0] exp_d_out;

  int errors;
  int checks;
  int seed_ret;

  trs_io_top #(
    .REQ_PULSE_CYCLES (REQ_CYCLES)
  ) trs_io_top_inst (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_fpga        (cs_fpga),
    .mosi           (mosi),
    .trs_in_n       (trs_in_n),
    .trs_out_n      (trs_out_n),
    .done           (done),
    .trs_a          (trs_a),
    .miso           (miso),
    .esp_s          (esp_s),
    .req            (req),
    .trs_wait       (trs_wait),
    .trs_int        (trs_int),
    .trs_d_out      (trs_d_out),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .led_err        (led_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic step;   // inputs change 1 ns after the edge
    @(posedge clk);
    #1;
  endtask

  task automatic hold(input int n);
    repeat (n) step;
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs;
    check("led_red", led_red, exp_red);
    check("led_green", led_green, exp_green);
    check("led_blue", led_blue, exp_blue);
    check("led_err", led_err, exp_err);
    check("trs_int", trs_int, exp_int);
    check("trs_d_out", trs_d_out, exp_d_out);
  endtask

  // service code the esp should see, straight from the port map
  function automatic logic [3:0] expected_code(input logic [7:0] addr, input logic rd);
    logic [3:0] code;
    if (addr == 8'd31)
      code = rd ? trs_io_in : trs_io_out;
    else if (addr >= 8'hc0 && addr <= 8'hcf)
      code = rd ? frehd_in : frehd_out;
    else if (addr >= 8'hf8 && addr <= 8'hfb)
      code = rd ? printer_rd : printer_wr;
    else
      code = idle_code;
    return code;
  endfunction

  function automatic logic [7:0] pick_port(input bit trapped);
    logic [7:0] a;
    if (trapped) begin
      case ($urandom_range(0, 2))
        0:       a = 8'd31;
        1:       a = 8'hc0 | 8'($urandom_range(0, 15));
        default: a = 8'hf8 + 8'($urandom_range(0, 3));
      endcase
    end else begin
      do a = 8'($urandom_range(0, 255));
      while (expected_code(a, 1'b1) != idle_code);   // reroll into a free port
    end
    return a;
  endfunction

  // spi mode 0 master, each sck level held 8 clocks
  task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
    rx = 8'h00;
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      hold(8);
      rx[i] = miso;   // stable since the last fall
      sck = 1'b1;
      hold(8);
      sck = 1'b0;
    end
  endtask

  task automatic cs_begin;
    cs_fpga = 1'b0;
    hold(8);
  endtask

  task automatic cs_end;
    hold(8);
    cs_fpga = 1'b1;
    hold(8);
  endtask

  task automatic send_cmd(input logic [7:0] c);
    logic [7:0] unused;
    cs_begin;
    spi_xfer(c, unused);
    cs_end;
  endtask

  task automatic send_cmd_param(input logic [7:0] c, input logic [7:0] p);
    logic [7:0] unused;
    cs_begin;
    spi_xfer(c, unused);
    hold(8);
    spi_xfer(p, unused);
    cs_end;
  endtask

  task automatic read_reply(input logic [7:0] c, output logic [7:0] rx);
    logic [7:0] unused;
    cs_begin;
    spi_xfer(c, unused);
    hold(8);
    spi_xfer(8'h00, rx);   // dummy byte clocks the reply out
    cs_end;
  endtask

  // esp side of one trapped access
  task automatic esp_respond(input logic [3:0] code);
    int n;
    int pulse;
    int cyc;
    int delay;
    delay = $urandom_range(60, 200);
    n = 0;
    while (!req && n < WAIT_LIMIT) begin
      step;
      n++;
    end
    if (!req) begin
      errors++;
      $display("req never rose for code %0d at t=%0t", code, $time);
      return;
    end
    pulse = 0;
    cyc   = 0;
    while (req && pulse <= REQ_CYCLES + 5) begin
      check("esp_s", esp_s, code);
      check("trs_wait", trs_wait, 1'b1);
      pulse++;
      cyc++;
      step;
    end
    check("req_pulse_cycles", pulse, REQ_CYCLES);
    while (cyc < delay) begin   // esp still busy, z80 must stay held
      check("trs_wait", trs_wait, 1'b1);
      check("req", req, 1'b0);
      cyc++;
      step;
    end
    done = 1'b1;
    n = 0;
    while (trs_wait && n < WAIT_LIMIT) begin
      step;
      n++;
    end
    if (trs_wait) begin
      errors++;
      $display("trs_wait stayed high after done at t=%0t", $time);
    end
    done = 1'b0;
  endtask

  task automatic io_access(input logic [7:0] addr, input logic rd);
    logic [3:0] code;
    int         n;
    code  = expected_code(addr, rd);
    trs_a = addr;
    step;
    if (rd)
      trs_in_n = 1'b0;
    else
      trs_out_n = 1'b0;
    if (code != idle_code) begin
      esp_respond(code);
    end else begin
      repeat (WAIT_LIMIT) begin   // free port, nothing may happen
        step;
        check("req", req, 1'b0);
        check("esp_s", esp_s, idle_code);
      end
    end
    trs_in_n  = 1'b1;
    trs_out_n = 1'b1;
    if (addr == 8'd31)
      exp_int = 1'b0;   // z80 saw trs-io
    n = 0;
    while (esp_s != idle_code && n < WAIT_LIMIT) begin
      step;
      n++;
    end
    if (esp_s != idle_code) begin
      errors++;
      $display("esp_s did not return to idle for port %0h at t=%0t", addr, $time);
    end
    step;
    check_outputs;
  endtask

  initial begin
    logic [7:0] rx;
    logic [7:0] p;
    logic [7:0] a;
    logic [7:0] c;
    errors         = 0;
    checks         = 0;
    seed_ret       = $urandom(32'h4dd0_f578);
    cass_out_sel_n = 1'b0;
    sck            = 1'b0;
    cs_fpga        = 1'b1;
    mosi           = 1'b0;
    trs_in_n       = 1'b1;
    trs_out_n      = 1'b1;
    done           = 1'b0;
    trs_a          = 8'h00;
    exp_red        = 1'b0;
    exp_green      = 1'b0;
    exp_blue       = 1'b0;
    exp_err        = 1'b0;
    exp_int        = 1'b0;
    exp_d_out      = 8'h00;
    repeat (2) @(posedge clk);
    #1 cass_out_sel_n = 1'b1;
    step;
    check("req", req, 1'b0);
    check("trs_wait", trs_wait, 1'b0);
    check("esp_s", esp_s, idle_code);
    check("miso", miso, 1'b0);
    check_outputs;

    // replies
    read_reply(get_cookie, rx);
    check("cookie_reply", rx, 8'haf);
    read_reply(get_version, rx);
    check("version_reply", rx, 8'h03);
    trs_a = 8'($urandom_range(0, 255));   // steady for the whole message
    read_reply(abus_read, rx);
    check("abus_reply", rx, trs_a);

    // leds and data bus
    repeat (12) begin
      p = 8'($urandom_range(0, 255));
      if ($urandom_range(0, 1) == 1) begin
        send_cmd_param(set_led, p);
        exp_red   = p[0];
        exp_green = p[1];
        exp_blue  = p[2];
      end else begin
        send_cmd_param(dbus_write, p);
        exp_d_out = p;
      end
      check_outputs;
    end

    // dbus_write cut short by cs, then a clean set_led
    send_cmd(dbus_write);
    check_outputs;
    p = 8'($urandom_range(0, 255));
    send_cmd_param(set_led, p);
    exp_red   = p[0];
    exp_green = p[1];
    exp_blue  = p[2];
    check_outputs;

    // port traps
    repeat (16) begin
      a = pick_port(1'($urandom_range(0, 1)));
      io_access(a, 1'($urandom_range(0, 1)));
    end

    // interrupt set by data_ready, cleared only by port 31
    send_cmd(data_ready);
    exp_int = 1'b1;
    check_outputs;
    repeat (4) begin
      a = pick_port(1'($urandom_range(0, 1)));
      if (a == 8'd31)
        a = 8'hc5;
      io_access(a, 1'($urandom_range(0, 1)));
    end
    io_access(8'd31, 1'($urandom_range(0, 1)));

    // unknown code, error led sticks
    do c = 8'($urandom_range(0, 255));
    while (c == 8'd0 || c == 8'd4 || c == 8'd5 || c == 8'd15 || c == 8'd18 || c == 8'd26);
    send_cmd(c);
    exp_err = 1'b1;
    check_outputs;
    send_cmd(get_cookie);
    check_outputs;

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: vlog.f
hw/trs_io_pkg.sv
hw/trs_io_ifs.sv
hw/spi_byte_port.sv
hw/cmd_parser.sv
hw/host_regs.sv
hw/trs_port_decode.sv
hw/esp_req_timer.sv
hw/trs_io_top.sv
tests/trs_io_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the bridge core with its testbench and run it under verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f vlog.f --top-module trs_io_tb -o trs_io_sim || exit 1
out="$(./obj_dir/trs_io_sim)"
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
